/* nanorv_core.f */
+incdir+source
source/nanorv_pkg.sv
source/nanorv_alu.sv
source/nanorv_decode.sv
source/nanorv_regfile.sv
source/nanorv_fetch.sv
source/nanorv_lsu.sv
source/nanorv_core.sv
tests/tb_nanorv_core.sv

/* Bender.yml */
package:
  name: nanorv_core

sources:
  - include_dirs:
      - source
    files:
      - source/nanorv_pkg.sv
      - source/nanorv_alu.sv
      - source/nanorv_decode.sv
      - source/nanorv_regfile.sv
      - source/nanorv_fetch.sv
      - source/nanorv_lsu.sv
      - source/nanorv_core.sv
      - target: test
        files:
          - tests/tb_nanorv_core.sv

/* tests/tb_nanorv_core.sv */
// Random program run against an instruction-level model; code space is 512 words, data 256 bytes
`default_nettype none
`timescale 1ns/1ps
`include "nanorv_defs.svh"

module tb_nanorv_core;

   localparam int          CODE_WORDS  = 512;
   localparam int          LAST_IDX    = 201;
   localparam int          FETCH_LIMIT = 3000;
   localparam int          WAIT_LIMIT  = 200;
   localparam logic [31:0] DATA_BASE   = 32'h0001_0000;

   logic        clk = 1'b0;
   logic        rst_n;
   logic [31:0] cpu_codemem_addr;
   logic        cpu_codemem_valid;
   logic [31:0] codemem_cpu_rdata;
   logic        codemem_cpu_ready;
   logic [31:0] cpu_datamem_addr;
   logic [31:0] cpu_datamem_wdata;
   logic        cpu_datamem_we;
   logic        cpu_datamem_valid;
   logic [31:0] datamem_cpu_rdata;
   logic        datamem_cpu_ready;

   logic [31:0] prog [0:CODE_WORDS-1];
   logic [31:0] dut_mem [logic [31:0]];
   logic [31:0] ref_mem [logic [31:0]];
   logic [31:0] ref_regs [0:31];
   logic [31:0] ref_pc;
   logic [31:0] exp_addr_q[$];
   logic [31:0] exp_data_q[$];
   logic        exp_we_q[$];
   int          err_count;
   int          fetches;
   int          accesses;
   int          final_hits;

   nanorv_core i_dut (.*);

   always #4 clk = ~clk;

   // ====================
   // Encoders and helpers
   function automatic logic [31:0] fill_word(input logic [31:0] a);
      return (a * 32'h9e37_79b9) ^ 32'h6b56_a5c3;
   endfunction

   function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], `NANORV_OP_STORE};
   endfunction

   function automatic logic [31:0] btype_word(input logic [12:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `NANORV_OP_BRANCH};
   endfunction

   function automatic logic [31:0] jtype_word(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `NANORV_OP_JAL};
   endfunction

   // Never x1, which holds the data base
   function automatic logic [4:0] pick_rd();
      logic [4:0] r;
      r = 5'($urandom % 31 + 1);
      return (r == 5'd1) ? 5'd0 : r;
   endfunction

   function automatic logic [2:0] pick_alu_f3();
      case ($urandom % 4)
         0:       return `NANORV_F3_ADD;
         1:       return `NANORV_F3_AND;
         2:       return `NANORV_F3_OR;
         default: return `NANORV_F3_XOR;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("ERR %s expected %h actual %h", name, expected, actual);
         err_count++;
      end
   endtask

   // ====================
   // Program generator
   task automatic build_program();
      int         kind;
      int         k;
      logic [4:0] rd;
      logic [4:0] rs1;
      logic [4:0] rs2;
      logic [2:0] f3;
      logic [11:0] imm;
      logic [11:0] off;
      for (int idx = 0; idx < CODE_WORDS; idx++) begin
         prog[idx] = jtype_word(21'd0, 5'd0);
      end
      prog[0] = {DATA_BASE[31:12], 5'd1, `NANORV_OP_LUI};
      for (int idx = 1; idx < LAST_IDX; idx++) begin
         rd   = pick_rd();
         rs1  = 5'($urandom % 32);
         rs2  = 5'($urandom % 32);
         imm  = 12'($urandom);
         off  = 12'(($urandom % 64) * 4);
         kind = (idx % 5 == 0) ? 7 : int'($urandom % 8);
         k    = 1 + int'($urandom % 8);
         if (idx + k > LAST_IDX) begin
            k = LAST_IDX - idx;
         end
         case (kind)
            0: begin
               f3 = pick_alu_f3();
               prog[idx] = {((f3 == `NANORV_F3_ADD) && ($urandom % 2 == 1)) ?
                            `NANORV_F7_SUB : 7'd0, rs2, rs1, f3, rd, `NANORV_OP_OP};
            end
            1: prog[idx] = {imm, rs1, pick_alu_f3(), rd, `NANORV_OP_OP_IMM};
            2: prog[idx] = {20'($urandom), rd, `NANORV_OP_LUI};
            3: prog[idx] = {20'($urandom), rd, `NANORV_OP_AUIPC};
            4: prog[idx] = jtype_word(21'(k * 4), rd);
            5: prog[idx] = btype_word(13'(k * 4), rs2, rs1,
                                      ($urandom % 2 == 1) ? `NANORV_F3_BNE : `NANORV_F3_BEQ);
            6: prog[idx] = {off, 5'd1, 3'b010, rd, `NANORV_OP_LOAD};
            default: prog[idx] = stype_word(off, rs2, 5'd1, 3'b010);
         endcase
      end
   endtask

   // ====================
   // Reference model, one instruction per call
   task automatic model_step();
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [31:0] npc;
      logic [31:0] addr;
      logic [31:0] imm_i;
      logic [31:0] imm_s;
      logic [31:0] imm_b;
      logic [31:0] imm_j;
      logic [2:0]  f3;
      logic        wr;
      w     = prog[ref_pc[10:2]];
      f3    = w[14:12];
      a     = ref_regs[w[19:15]];
      b     = ref_regs[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      npc   = ref_pc + 32'd4;
      wr    = 1'b0;
      res   = '0;
      case (w[6:0])
         `NANORV_OP_OP, `NANORV_OP_OP_IMM: begin
            if (w[6:0] == `NANORV_OP_OP_IMM) begin
               b = imm_i;
            end
            wr = 1'b1;
            case (f3)
               3'b000:  res = (w[6:0] == `NANORV_OP_OP && w[30]) ? a - b : a + b;
               3'b111:  res = a & b;
               3'b110:  res = a | b;
               3'b100:  res = a ^ b;
               default: wr = 1'b0;
            endcase
         end
         `NANORV_OP_LUI: begin
            res = {w[31:12], 12'b0};
            wr  = 1'b1;
         end
         `NANORV_OP_AUIPC: begin
            res = ref_pc + {w[31:12], 12'b0};
            wr  = 1'b1;
         end
         `NANORV_OP_JAL: begin
            res = ref_pc + 32'd4;
            npc = ref_pc + imm_j;
            wr  = 1'b1;
         end
         `NANORV_OP_BRANCH: begin
            if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
               npc = ref_pc + imm_b;
            end
         end
         `NANORV_OP_LOAD: begin
            addr = a + imm_i;
            res  = ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
            wr   = 1'b1;
            exp_addr_q.push_back(addr);
            exp_we_q.push_back(1'b0);
            exp_data_q.push_back('0);
         end
         `NANORV_OP_STORE: begin
            addr          = a + imm_s;
            ref_mem[addr] = b;
            exp_addr_q.push_back(addr);
            exp_we_q.push_back(1'b1);
            exp_data_q.push_back(b);
         end
         default: ;
      endcase
      if (wr && w[11:7] != 5'd0) begin
         ref_regs[w[11:7]] = res;
      end
      ref_pc = npc;
   endtask

   // ====================
   // Memory responders
   task automatic wait_request(output bit is_code);
      int cycles;
      cycles = 0;
      while (!cpu_codemem_valid && !cpu_datamem_valid) begin
         if (cycles == WAIT_LIMIT) begin
            $display("Timeout: no code or data request within %0d cycles", WAIT_LIMIT);
            $display("Simulation FAILED");
            $finish;
         end
         @(negedge clk);
         cycles++;
      end
      if (cpu_codemem_valid && cpu_datamem_valid) begin
         $display("Code and data requests are both active at %0t", $time);
         err_count++;
      end
      is_code = cpu_codemem_valid;
   endtask

   task automatic serve_fetch();
      logic [31:0] addr;
      int          delay;
      addr  = cpu_codemem_addr;
      delay = int'($urandom % 4);
      if (fetches == 0) begin
         check_value("first fetch", `NANORV_RESET_PC, addr);
      end
      check_value("fetch addr", ref_pc, addr);
      for (int i = 0; i < delay; i++) begin
         @(negedge clk);
         check_value("code valid hold", 32'd1, 32'(cpu_codemem_valid));
         check_value("code addr hold", addr, cpu_codemem_addr);
         check_value("data valid in fetch", 32'd0, 32'(cpu_datamem_valid));
      end
      codemem_cpu_rdata = prog[addr[10:2]];
      codemem_cpu_ready = 1'b1;
      @(negedge clk);
      codemem_cpu_ready = 1'b0;
      codemem_cpu_rdata = '0;
      if (addr == 32'(LAST_IDX * 4)) begin
         final_hits++;
      end
      model_step();
      fetches++;
   endtask

   task automatic serve_data();
      logic [31:0] addr;
      logic [31:0] wdata;
      logic        we;
      int          delay;
      addr  = cpu_datamem_addr;
      wdata = cpu_datamem_wdata;
      we    = cpu_datamem_we;
      delay = int'($urandom % 4);
      if (exp_addr_q.size() == 0) begin
         $display("Data request at %h with no access expected by the model", addr);
         err_count++;
      end else begin
         check_value("data addr", exp_addr_q.pop_front(), addr);
         check_value("data dir", 32'(exp_we_q[0]), 32'(we));
         if (exp_we_q.pop_front()) begin
            check_value("store data", exp_data_q[0], wdata);
         end
         void'(exp_data_q.pop_front());
      end
      for (int i = 0; i < delay; i++) begin
         @(negedge clk);
         check_value("data valid hold", 32'd1, 32'(cpu_datamem_valid));
         check_value("data addr hold", addr, cpu_datamem_addr);
         check_value("wdata hold", wdata, cpu_datamem_wdata);
         check_value("dir hold", 32'(we), 32'(cpu_datamem_we));
         check_value("code valid in data", 32'd0, 32'(cpu_codemem_valid));
      end
      if (we) begin
         dut_mem[addr] = wdata;
      end else begin
         datamem_cpu_rdata = dut_mem.exists(addr) ? dut_mem[addr] : fill_word(addr);
      end
      datamem_cpu_ready = 1'b1;
      @(negedge clk);
      datamem_cpu_ready = 1'b0;
      datamem_cpu_rdata = '0;
      accesses++;
   endtask

   // ====================
   // Main sequence
   initial begin
      bit is_code;
      rst_n             = 1'b0;
      codemem_cpu_rdata = '0;
      codemem_cpu_ready = 1'b0;
      datamem_cpu_rdata = '0;
      datamem_cpu_ready = 1'b0;
      err_count         = 0;
      fetches           = 0;
      accesses          = 0;
      final_hits        = 0;
      ref_pc            = `NANORV_RESET_PC;
      void'($urandom(32'h6b56));
      for (int i = 0; i < 32; i++) begin
         ref_regs[i] = '0;
      end
      build_program();

      for (int i = 0; i < 16; i++) begin
         @(negedge clk);
         check_value("reset code valid", 32'd0, 32'(cpu_codemem_valid));
         check_value("reset data valid", 32'd0, 32'(cpu_datamem_valid));
      end
      rst_n = 1'b1;
      // First fetch request one clock after release
      @(negedge clk);
      check_value("code valid after release", 32'd1, 32'(cpu_codemem_valid));
      check_value("data valid after release", 32'd0, 32'(cpu_datamem_valid));

      while (final_hits < 2 && fetches < FETCH_LIMIT && accesses < FETCH_LIMIT) begin
         wait_request(is_code);
         if (is_code) begin
            serve_fetch();
         end else begin
            serve_data();
         end
      end

      if (final_hits < 2) begin
         $display("Fetch or data access limit of %0d reached before the final JAL",
                  FETCH_LIMIT);
         err_count++;
      end
      if (exp_addr_q.size() != 0) begin
         $display("%0d data accesses expected by the model never appeared", exp_addr_q.size());
         err_count++;
      end
      $display("Run finished after %0d fetches with %0d errors", fetches, err_count);
      if (err_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* source/nanorv_core.sv */
// Multi-cycle RV32I subset core; code and data memories are external, word wide, valid/ready
`default_nettype none
`timescale 1ns/1ps
`include "nanorv_defs.svh"

module nanorv_core (
   input  logic                    clk,
   input  logic                    rst_n,
   // Code memory
   output logic [`NANORV_XLEN-1:0] cpu_codemem_addr,
   output logic                    cpu_codemem_valid,
   input  logic [`NANORV_XLEN-1:0] codemem_cpu_rdata,
   input  logic                    codemem_cpu_ready,
   // Data memory
   output logic [`NANORV_XLEN-1:0] cpu_datamem_addr,
   output logic [`NANORV_XLEN-1:0] cpu_datamem_wdata,
   output logic                    cpu_datamem_we,
   output logic                    cpu_datamem_valid,
   input  logic [`NANORV_XLEN-1:0] datamem_cpu_rdata,
   input  logic                    datamem_cpu_ready
);

   import nanorv_pkg::*;

   // ====================
   // Sequencer outputs
   insn_u                       instr;
   logic [`NANORV_XLEN-1:0]     pc;
   logic                        exec;

   // Decode to ALU and write-back
   logic [`NANORV_XLEN-1:0]     alu_a;
   logic [`NANORV_XLEN-1:0]     alu_b;
   logic [`NANORV_ALU_OP_W-1:0] alu_op;
   logic                        rd_we_alu;
   logic                        rd_we_link;
   logic                        jump;
   logic                        branch_eq;
   logic                        branch_ne;
   logic                        load;
   logic                        store;
   logic [`NANORV_XLEN-1:0]     imm_target;

   // Datapath results
   logic [`NANORV_XLEN-1:0]     rs1_data;
   logic [`NANORV_XLEN-1:0]     rs2_data;
   logic [`NANORV_XLEN-1:0]     alu_res;
   logic                        alu_eq;

   // Load/store return
   logic                        mem_busy;
   logic [`NANORV_XLEN-1:0]     load_data;
   logic                        load_we;

   // ====================
   // All port names match the nets above
   nanorv_fetch   i_fetch   (.*);
   nanorv_decode  i_decode  (.*);
   nanorv_regfile i_regfile (.*);
   nanorv_alu     i_alu     (.*);
   nanorv_lsu     i_lsu     (.*);

endmodule

`default_nettype wire

/* source/nanorv_lsu.sv */
// Word-only data port; one request at a time, held stable until the memory raises ready
`default_nettype none
`timescale 1ns/1ps
`include "nanorv_defs.svh"

module nanorv_lsu (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    exec,
   input  logic                    load,
   input  logic                    store,
   input  logic [`NANORV_XLEN-1:0] alu_res,
   input  logic [`NANORV_XLEN-1:0] rs2_data,
   input  logic [`NANORV_XLEN-1:0] datamem_cpu_rdata,
   input  logic                    datamem_cpu_ready,
   output logic [`NANORV_XLEN-1:0] cpu_datamem_addr,
   output logic [`NANORV_XLEN-1:0] cpu_datamem_wdata,
   output logic                    cpu_datamem_we,
   output logic                    cpu_datamem_valid,
   output logic                    mem_busy,
   output logic [`NANORV_XLEN-1:0] load_data,
   output logic                    load_we
);

   logic start;
   logic done;

   assign start = exec & (load | store);
   assign done  = cpu_datamem_valid & datamem_cpu_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cpu_datamem_valid <= 1'b0;
         cpu_datamem_we    <= 1'b0;
      end else if (start) begin
         cpu_datamem_valid <= 1'b1;
         cpu_datamem_we    <= store;
      end else if (done) begin
         cpu_datamem_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         cpu_datamem_addr  <= alu_res;
         cpu_datamem_wdata <= rs2_data;
      end
   end

   // Busy from the execute cycle up to, not including, the completion cycle
   assign mem_busy  = start | (cpu_datamem_valid & ~datamem_cpu_ready);
   assign load_we   = done & ~cpu_datamem_we;
   assign load_data = datamem_cpu_rdata;

   data_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      cpu_datamem_valid && !datamem_cpu_ready |=> cpu_datamem_valid &&
         $stable({cpu_datamem_addr, cpu_datamem_wdata, cpu_datamem_we}))
      else $error("data request changed before ready");

endmodule

`default_nettype wire

/* source/nanorv_fetch.sv */
// Multi-cycle sequencer with one instruction in flight; no prefetch, traps or misaligned PCs
`default_nettype none
`timescale 1ns/1ps
`include "nanorv_defs.svh"

module nanorv_fetch (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [`NANORV_XLEN-1:0] codemem_cpu_rdata,
   input  logic                    codemem_cpu_ready,
   input  logic                    mem_busy,
   input  logic                    jump,
   input  logic                    branch_eq,
   input  logic                    branch_ne,
   input  logic                    alu_eq,
   input  logic [`NANORV_XLEN-1:0] imm_target,
   output logic [`NANORV_XLEN-1:0] cpu_codemem_addr,
   output logic                    cpu_codemem_valid,
   output nanorv_pkg::insn_u       instr,
   output logic [`NANORV_XLEN-1:0] pc,
   output logic                    exec
);

   import nanorv_pkg::*;

   localparam logic [1:0] PH_FETCH = 2'd0;
   localparam logic [1:0] PH_EXEC  = 2'd1;
   localparam logic [1:0] PH_MEM   = 2'd2;

   logic [1:0]              phase;
   logic                    take;
   logic [`NANORV_XLEN-1:0] pc_next;

   assign take    = jump | (branch_eq & alu_eq) | (branch_ne & ~alu_eq);
   assign pc_next = take ? imm_target : pc + 32'd4;

   assign exec             = (phase == PH_EXEC);
   assign cpu_codemem_addr = pc;

   // ====================
   // Phase sequencer
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         phase             <= PH_FETCH;
         pc                <= `NANORV_RESET_PC;
         cpu_codemem_valid <= 1'b0;
         instr             <= '0;
      end else begin
         case (phase)
            PH_FETCH: begin
               // Valid is only low here in the first cycle out of reset
               if (!cpu_codemem_valid) begin
                  cpu_codemem_valid <= 1'b1;
               end else if (codemem_cpu_ready) begin
                  cpu_codemem_valid <= 1'b0;
                  instr.raw         <= codemem_cpu_rdata;
                  phase             <= PH_EXEC;
               end
            end
            default: begin
               // Execute cycle, then wait here while the LSU holds the data bus
               if (phase == PH_EXEC) begin
                  pc <= pc_next;
               end
               if (mem_busy) begin
                  phase <= PH_MEM;
               end else begin
                  phase             <= PH_FETCH;
                  cpu_codemem_valid <= 1'b1;
               end
            end
         endcase
      end
   end

   // ====================
   // Code bus checks
   code_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      cpu_codemem_valid && !codemem_cpu_ready |=>
         cpu_codemem_valid && $stable(cpu_codemem_addr))
      else $error("code request dropped or moved before ready");

   code_addr_align: assert property (@(posedge clk) disable iff (!rst_n)
      cpu_codemem_valid |-> cpu_codemem_addr[1:0] == 2'b00)
      else $error("code address not word aligned");

endmodule

`default_nettype wire

/* source/nanorv_regfile.sv */
// 32 x 32-bit register file; x0 is never written, reads are combinational from instr fields
`default_nettype none
`timescale 1ns/1ps
`include "nanorv_defs.svh"

module nanorv_regfile (
   input  logic                    clk,
   input  logic                    rst_n,
   input  nanorv_pkg::insn_u       instr,
   input  logic                    exec,
   input  logic                    rd_we_alu,
   input  logic                    rd_we_link,
   input  logic [`NANORV_XLEN-1:0] alu_res,
   input  logic [`NANORV_XLEN-1:0] pc,
   input  logic                    load_we,
   input  logic [`NANORV_XLEN-1:0] load_data,
   output logic [`NANORV_XLEN-1:0] rs1_data,
   output logic [`NANORV_XLEN-1:0] rs2_data
);

   import nanorv_pkg::*;

   logic [`NANORV_XLEN-1:0] regs [0:(1 << `NANORV_REG_AW)-1];
   logic                    wr_en;
   logic [`NANORV_XLEN-1:0] wr_data;

   // ALU and link results close the execute cycle, load data lands at bus completion
   always_comb begin
      wr_en   = load_we;
      wr_data = load_data;
      if (exec && rd_we_alu) begin
         wr_en   = 1'b1;
         wr_data = alu_res;
      end else if (exec && rd_we_link) begin
         wr_en   = 1'b1;
         wr_data = pc + 32'd4;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < (1 << `NANORV_REG_AW); i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && (instr.r.rd != '0)) begin
         regs[instr.r.rd] <= wr_data;
      end
   end

   // Entry 0 keeps its reset value, so x0 reads zero
   assign rs1_data = regs[instr.r.rs1];
   assign rs2_data = regs[instr.r.rs2];

endmodule

`default_nettype wire

/* source/nanorv_decode.sv */
// Combinational decode of the kept RV32I subset; any other encoding retires with no strobes
`default_nettype none
`timescale 1ns/1ps
`include "nanorv_defs.svh"

module nanorv_decode (
   input  nanorv_pkg::insn_u           instr,
   input  logic [`NANORV_XLEN-1:0]     pc,
   input  logic [`NANORV_XLEN-1:0]     rs1_data,
   input  logic [`NANORV_XLEN-1:0]     rs2_data,
   output logic [`NANORV_XLEN-1:0]     alu_a,
   output logic [`NANORV_XLEN-1:0]     alu_b,
   output logic [`NANORV_ALU_OP_W-1:0] alu_op,
   output logic                        rd_we_alu,
   output logic                        rd_we_link,
   output logic                        jump,
   output logic                        branch_eq,
   output logic                        branch_ne,
   output logic                        load,
   output logic                        store,
   output logic [`NANORV_XLEN-1:0]     imm_target
);

   import nanorv_pkg::*;

   logic [6:0]                   opcode;
   logic [`NANORV_XLEN-1:0]      imm_i;
   logic [`NANORV_XLEN-1:0]      imm_s;
   logic [`NANORV_XLEN-1:0]      imm_b;
   logic [`NANORV_XLEN-1:0]      imm_u;
   logic [`NANORV_XLEN-1:0]      imm_j;
   logic [`NANORV_ALU_OP_W-1:0]  f3_op;
   logic                         f3_ok;
   logic                         is_sub;

   assign opcode = instr.raw[6:0];

   // ====================
   // Immediate rebuild
   assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
   assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
   assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                   instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
   assign imm_u = {instr.u.imm_31_12, 12'b0};
   assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                   instr.j.imm_11, instr.j.imm_10_1, 1'b0};

   assign imm_target = pc + ((opcode == `NANORV_OP_JAL) ? imm_j : imm_b);

   // Shared by register and immediate ALU forms
   always_comb begin
      f3_ok = 1'b1;
      case (instr.r.funct3)
         `NANORV_F3_ADD: f3_op = `NANORV_ALU_ADD;
         `NANORV_F3_AND: f3_op = `NANORV_ALU_AND;
         `NANORV_F3_OR:  f3_op = `NANORV_ALU_OR;
         `NANORV_F3_XOR: f3_op = `NANORV_ALU_XOR;
         default: begin
            f3_op = `NANORV_ALU_ADD;
            f3_ok = 1'b0;
         end
      endcase
   end

   assign is_sub = (instr.r.funct7 == `NANORV_F7_SUB) && (instr.r.funct3 == `NANORV_F3_ADD);

   // ====================
   // Operand select and strobes
   always_comb begin
      alu_a      = rs1_data;
      alu_b      = rs2_data;
      alu_op     = `NANORV_ALU_ADD;
      rd_we_alu  = 1'b0;
      rd_we_link = 1'b0;
      jump       = 1'b0;
      branch_eq  = 1'b0;
      branch_ne  = 1'b0;
      load       = 1'b0;
      store      = 1'b0;
      case (opcode)
         `NANORV_OP_OP: begin
            alu_op    = is_sub ? `NANORV_ALU_SUB : f3_op;
            rd_we_alu = f3_ok;
         end
         `NANORV_OP_OP_IMM: begin
            alu_b     = imm_i;
            alu_op    = f3_op;
            rd_we_alu = f3_ok;
         end
         `NANORV_OP_LUI: begin
            alu_b     = imm_u;
            alu_op    = `NANORV_ALU_PASS_B;
            rd_we_alu = 1'b1;
         end
         `NANORV_OP_AUIPC: begin
            alu_a     = pc;
            alu_b     = imm_u;
            rd_we_alu = 1'b1;
         end
         `NANORV_OP_JAL: begin
            jump       = 1'b1;
            rd_we_link = 1'b1;
         end
         `NANORV_OP_BRANCH: begin
            branch_eq = (instr.b.funct3 == `NANORV_F3_BEQ);
            branch_ne = (instr.b.funct3 == `NANORV_F3_BNE);
         end
         // Any LOAD/STORE funct3 is treated as a full word
         `NANORV_OP_LOAD: begin
            alu_b = imm_i;
            load  = 1'b1;
         end
         `NANORV_OP_STORE: begin
            alu_b = imm_s;
            store = 1'b1;
         end
         default: begin
            alu_op = `NANORV_ALU_ADD;
         end
      endcase
   end

endmodule

`default_nettype wire

/* source/nanorv_alu.sv */
// Combinational ALU with add, sub, bitwise ops and pass-B; no shifts or ordered compares
`default_nettype none
`timescale 1ns/1ps
`include "nanorv_defs.svh"

module nanorv_alu (
   input  logic [`NANORV_XLEN-1:0]     alu_a,
   input  logic [`NANORV_XLEN-1:0]     alu_b,
   input  logic [`NANORV_ALU_OP_W-1:0] alu_op,
   output logic [`NANORV_XLEN-1:0]     alu_res,
   output logic                        alu_eq
);

   always_comb begin
      case (alu_op)
         `NANORV_ALU_ADD:    alu_res = alu_a + alu_b;
         `NANORV_ALU_SUB:    alu_res = alu_a - alu_b;
         `NANORV_ALU_AND:    alu_res = alu_a & alu_b;
         `NANORV_ALU_OR:     alu_res = alu_a | alu_b;
         `NANORV_ALU_XOR:    alu_res = alu_a ^ alu_b;
         // LUI immediate goes straight through
         `NANORV_ALU_PASS_B: alu_res = alu_b;
         default:            alu_res = '0;
      endcase
   end

   // Branch compare on the raw operands, whatever alu_op is
   assign alu_eq = (alu_a == alu_b);

endmodule

`default_nettype wire

/* source/nanorv_pkg.sv */
// Field views of a 32-bit RV32I instruction word; compressed encodings are not covered
`default_nettype none
`include "nanorv_defs.svh"

package nanorv_pkg;

   typedef struct packed {
      logic [6:0]                funct7;
      logic [`NANORV_REG_AW-1:0] rs2;
      logic [`NANORV_REG_AW-1:0] rs1;
      logic [2:0]                funct3;
      logic [`NANORV_REG_AW-1:0] rd;
      logic [6:0]                opcode;
   } insn_r_t;

   typedef struct packed {
      logic [11:0]               imm;
      logic [`NANORV_REG_AW-1:0] rs1;
      logic [2:0]                funct3;
      logic [`NANORV_REG_AW-1:0] rd;
      logic [6:0]                opcode;
   } insn_i_t;

   typedef struct packed {
      logic [6:0]                imm_hi;
      logic [`NANORV_REG_AW-1:0] rs2;
      logic [`NANORV_REG_AW-1:0] rs1;
      logic [2:0]                funct3;
      logic [4:0]                imm_lo;
      logic [6:0]                opcode;
   } insn_s_t;

   // Branch offset bits are scattered, bit 0 implied zero
   typedef struct packed {
      logic                      imm_12;
      logic [5:0]                imm_10_5;
      logic [`NANORV_REG_AW-1:0] rs2;
      logic [`NANORV_REG_AW-1:0] rs1;
      logic [2:0]                funct3;
      logic [3:0]                imm_4_1;
      logic                      imm_11;
      logic [6:0]                opcode;
   } insn_b_t;

   typedef struct packed {
      logic [19:0]               imm_31_12;
      logic [`NANORV_REG_AW-1:0] rd;
      logic [6:0]                opcode;
   } insn_u_t;

   typedef struct packed {
      logic                      imm_20;
      logic [9:0]                imm_10_1;
      logic                      imm_11;
      logic [7:0]                imm_19_12;
      logic [`NANORV_REG_AW-1:0] rd;
      logic [6:0]                opcode;
   } insn_j_t;

   // One instruction word, seen raw or through any format
   typedef union packed {
      logic [`NANORV_XLEN-1:0] raw;
      insn_r_t                 r;
      insn_i_t                 i;
      insn_s_t                 s;
      insn_b_t                 b;
      insn_u_t                 u;
      insn_j_t                 j;
   } insn_u;

endpackage

`default_nettype wire

/* source/nanorv_defs.svh */
// Encodings for a 32-bit RV32I subset with word-only memory access; XLEN is fixed at 32
`ifndef NANORV_DEFS_SVH
`define NANORV_DEFS_SVH

`define NANORV_XLEN         32
`define NANORV_REG_AW       5
`define NANORV_RESET_PC     32'h0000_0000

// ====================
// Major opcodes kept
`define NANORV_OP_OP        7'b0110011
`define NANORV_OP_OP_IMM    7'b0010011
`define NANORV_OP_LUI       7'b0110111
`define NANORV_OP_AUIPC     7'b0010111
`define NANORV_OP_JAL       7'b1101111
`define NANORV_OP_BRANCH    7'b1100011
`define NANORV_OP_LOAD      7'b0000011
`define NANORV_OP_STORE     7'b0100011

// funct3 / funct7 values
`define NANORV_F3_ADD       3'b000
`define NANORV_F3_AND       3'b111
`define NANORV_F3_OR        3'b110
`define NANORV_F3_XOR       3'b100
`define NANORV_F3_BEQ       3'b000
`define NANORV_F3_BNE       3'b001
`define NANORV_F7_SUB       7'b0100000

// ====================
// ALU operation codes
`define NANORV_ALU_OP_W     3
`define NANORV_ALU_ADD      3'd0
`define NANORV_ALU_SUB      3'd1
`define NANORV_ALU_AND      3'd2
`define NANORV_ALU_OR       3'd3
`define NANORV_ALU_XOR      3'd4
`define NANORV_ALU_PASS_B   3'd5

`endif
